// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = decode_stage_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir

.PHONY: sim clean

# build and run; a $fatal in the testbench gives a failing exit status.
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [rv_decode_pkg::XLEN-1:0]  instruction,
    output logic [rv_decode_pkg::OP_W-1:0]  op,
    output logic [rv_decode_pkg::REG_W-1:0] rs1,
    output logic [rv_decode_pkg::REG_W-1:0] rs2,
    output logic [rv_decode_pkg::REG_W-1:0] rd,
    output logic [rv_decode_pkg::XLEN-1:0]  imm,
    output logic                            has_imm
);

    rv_decode_pkg::rv_instr_u word;

    logic [rv_decode_pkg::OP_W-1:0]  base_op;
    logic [rv_decode_pkg::REG_W-1:0] base_rs1;
    logic [rv_decode_pkg::REG_W-1:0] base_rs2;
    logic [rv_decode_pkg::REG_W-1:0] base_rd;
    logic [rv_decode_pkg::XLEN-1:0]  base_imm;
    logic                            base_has_imm;

    logic [rv_decode_pkg::OP_W-1:0]  c_op;
    logic [rv_decode_pkg::REG_W-1:0] c_rs1;
    logic [rv_decode_pkg::REG_W-1:0] c_rs2;
    logic [rv_decode_pkg::REG_W-1:0] c_rd;
    logic [rv_decode_pkg::XLEN-1:0]  c_imm;
    logic                            c_has_imm;

    logic is_base;

    assign word    = instruction;
    assign is_base = (word.c.quadrant == 2'b11);

    rv32_base_decoder u_base (
        .instruction (word),
        .op          (base_op),
        .rs1         (base_rs1),
        .rs2         (base_rs2),
        .rd          (base_rd),
        .imm         (base_imm),
        .has_imm     (base_has_imm)
    );

    rvc_decoder u_rvc (
        .instruction (word),
        .op          (c_op),
        .rs1         (c_rs1),
        .rs2         (c_rs2),
        .rd          (c_rd),
        .imm         (c_imm),
        .has_imm     (c_has_imm)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one register stage.
    always_ff @(posedge clk) begin
        if (!rst) begin
            op      <= rv_decode_pkg::OP_NONE;
            rs1     <= '0;
            rs2     <= '0;
            rd      <= '0;
            imm     <= '0;
            has_imm <= 1'b0;
        end else begin
            op      <= is_base ? base_op : c_op;
            rs1     <= is_base ? base_rs1 : c_rs1;
            rs2     <= is_base ? base_rs2 : c_rs2;
            rd      <= is_base ? base_rd : c_rd;
            imm     <= is_base ? base_imm : c_imm;
            has_imm <= is_base ? base_has_imm : c_has_imm;
        end
    end

    // codes 29 and 30 are never issued.
    a_op_range: assert property (@(posedge clk) !(op inside {5'd29, 5'd30}));

    a_imm_zero: assert property (@(posedge clk) !has_imm |-> imm == '0);

    a_reset_state: assert property (@(posedge clk)
        !rst |=> op == rv_decode_pkg::OP_NONE && {rs1, rs2, rd} == '0 && !has_imm);

endmodule

// ==== hw/rv32_base_decoder.sv ====
`timescale 1ns/100ps

module rv32_base_decoder (
    input  rv_decode_pkg::rv_instr_u        instruction,
    output logic [rv_decode_pkg::OP_W-1:0]  op,
    output logic [rv_decode_pkg::REG_W-1:0] rs1,
    output logic [rv_decode_pkg::REG_W-1:0] rs2,
    output logic [rv_decode_pkg::REG_W-1:0] rd,
    output logic [rv_decode_pkg::XLEN-1:0]  imm,
    output logic                            has_imm
);

    logic [rv_decode_pkg::XLEN-1:0] imm_i;
    logic [rv_decode_pkg::XLEN-1:0] imm_s;
    logic [rv_decode_pkg::XLEN-1:0] imm_b;
    logic [rv_decode_pkg::XLEN-1:0] imm_u;
    logic [rv_decode_pkg::XLEN-1:0] imm_j;
    logic [rv_decode_pkg::XLEN-1:0] imm_sh;

    // immediate formats.
    assign imm_i  = {{20{instruction[31]}}, instruction[31:20]};
    assign imm_s  = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign imm_b  = {{20{instruction[31]}}, instruction[7], instruction[30:25],
                     instruction[11:8], 1'b0};
    assign imm_u  = {instruction[31:12], 12'b0};
    assign imm_j  = {{12{instruction[31]}}, instruction[19:12], instruction[20],
                     instruction[30:21], 1'b0};
    assign imm_sh = {27'b0, instruction.b.rs2};

    always_comb begin
        op      = rv_decode_pkg::OP_NONE;
        rs1     = '0;
        rs2     = '0;
        rd      = '0;
        imm     = '0;
        has_imm = 1'b0;
        case (instruction.b.opcode)
            rv_decode_pkg::OPC_LUI, rv_decode_pkg::OPC_AUIPC: begin
                op      = (instruction.b.opcode == rv_decode_pkg::OPC_LUI) ?
                          rv_decode_pkg::OP_LUI : rv_decode_pkg::OP_AUIPC;
                rd      = instruction.b.rd;
                imm     = imm_u;
                has_imm = 1'b1;
            end
            rv_decode_pkg::OPC_JAL: begin
                op      = rv_decode_pkg::OP_JAL;
                rd      = instruction.b.rd;
                imm     = imm_j;
                has_imm = 1'b1;
            end
            rv_decode_pkg::OPC_JALR: begin
                if (instruction.b.funct3 == 3'b000) begin
                    op = rv_decode_pkg::OP_JALR;
                end
                rs1     = instruction.b.rs1;
                rd      = instruction.b.rd;
                imm     = imm_i;
                has_imm = 1'b1;
            end
            rv_decode_pkg::OPC_BRANCH: begin
                case (instruction.b.funct3)
                    3'b000: op = rv_decode_pkg::OP_BEQ;
                    3'b001: op = rv_decode_pkg::OP_BNE;
                    3'b100: op = rv_decode_pkg::OP_BLT;
                    3'b101: op = rv_decode_pkg::OP_BGE;
                    3'b110: op = rv_decode_pkg::OP_BLTU;
                    3'b111: op = rv_decode_pkg::OP_BGEU;
                    default: op = rv_decode_pkg::OP_NONE;
                endcase
                rs1     = instruction.b.rs1;
                rs2     = instruction.b.rs2;
                imm     = imm_b;
                has_imm = 1'b1;
            end
            rv_decode_pkg::OPC_LOAD: begin
                case (instruction.b.funct3)
                    3'b000: op = rv_decode_pkg::OP_LB;
                    3'b001: op = rv_decode_pkg::OP_LH;
                    3'b010: op = rv_decode_pkg::OP_LW;
                    3'b100: op = rv_decode_pkg::OP_LBU;
                    3'b101: op = rv_decode_pkg::OP_LHU;
                    default: op = rv_decode_pkg::OP_NONE;
                endcase
                rs1     = instruction.b.rs1;
                rd      = instruction.b.rd;
                imm     = imm_i;
                has_imm = 1'b1;
            end
            rv_decode_pkg::OPC_STORE: begin
                case (instruction.b.funct3)
                    3'b000: op = rv_decode_pkg::OP_SB;
                    3'b001: op = rv_decode_pkg::OP_SH;
                    3'b010: op = rv_decode_pkg::OP_SW;
                    default: op = rv_decode_pkg::OP_NONE;
                endcase
                rs1     = instruction.b.rs1;
                rs2     = instruction.b.rs2;
                imm     = imm_s;
                has_imm = 1'b1;
            end
            rv_decode_pkg::OPC_OP_IMM: begin
                case (instruction.b.funct3)
                    3'b000: op = rv_decode_pkg::OP_ADD;
                    3'b010: op = rv_decode_pkg::OP_SLT;
                    3'b011: op = rv_decode_pkg::OP_SLTU;
                    3'b100: op = rv_decode_pkg::OP_XOR;
                    3'b110: op = rv_decode_pkg::OP_OR;
                    3'b111: op = rv_decode_pkg::OP_AND;
                    3'b001: begin
                        if (instruction.b.funct7 == rv_decode_pkg::F7_ZERO) begin
                            op = rv_decode_pkg::OP_SLL;
                        end
                    end
                    default: begin
                        if (instruction.b.funct7 == rv_decode_pkg::F7_ZERO) begin
                            op = rv_decode_pkg::OP_SRL;
                        end else if (instruction.b.funct7 == rv_decode_pkg::F7_ALT) begin
                            op = rv_decode_pkg::OP_SRA;
                        end
                    end
                endcase
                rs1     = instruction.b.rs1;
                rd      = instruction.b.rd;
                // shifts carry shamt only.
                imm     = (instruction.b.funct3[1:0] == 2'b01) ? imm_sh : imm_i;
                has_imm = 1'b1;
            end
            rv_decode_pkg::OPC_OP: begin
                if (instruction.b.funct7 == rv_decode_pkg::F7_ZERO) begin
                    case (instruction.b.funct3)
                        3'b000: op = rv_decode_pkg::OP_ADD;
                        3'b001: op = rv_decode_pkg::OP_SLL;
                        3'b010: op = rv_decode_pkg::OP_SLT;
                        3'b011: op = rv_decode_pkg::OP_SLTU;
                        3'b100: op = rv_decode_pkg::OP_XOR;
                        3'b101: op = rv_decode_pkg::OP_SRL;
                        3'b110: op = rv_decode_pkg::OP_OR;
                        default: op = rv_decode_pkg::OP_AND;
                    endcase
                end else if (instruction.b.funct7 == rv_decode_pkg::F7_ALT) begin
                    case (instruction.b.funct3)
                        3'b000: op = rv_decode_pkg::OP_SUB;
                        3'b101: op = rv_decode_pkg::OP_SRA;
                        default: op = rv_decode_pkg::OP_NONE;
                    endcase
                end
                rs1 = instruction.b.rs1;
                rs2 = instruction.b.rs2;
                rd  = instruction.b.rd;
            end
            default: op = rv_decode_pkg::OP_NONE;
        endcase
        // bad funct codes clear every field.
        if (op == rv_decode_pkg::OP_NONE) begin
            rs1     = '0;
            rs2     = '0;
            rd      = '0;
            imm     = '0;
            has_imm = 1'b0;
        end
    end

endmodule

// ==== hw/rv_decode_pkg.sv ====
package rv_decode_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths.
    localparam int XLEN  = 32;
    localparam int REG_W = 5;
    localparam int OP_W  = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // internal operation codes.
    localparam logic [OP_W-1:0] OP_ADD   = 5'd0;
    localparam logic [OP_W-1:0] OP_AND   = 5'd1;
    localparam logic [OP_W-1:0] OP_OR    = 5'd2;
    localparam logic [OP_W-1:0] OP_SLL   = 5'd3;
    localparam logic [OP_W-1:0] OP_SRL   = 5'd4;
    localparam logic [OP_W-1:0] OP_SLT   = 5'd5;
    localparam logic [OP_W-1:0] OP_SLTU  = 5'd6;
    localparam logic [OP_W-1:0] OP_SRA   = 5'd7;
    localparam logic [OP_W-1:0] OP_SUB   = 5'd8;
    localparam logic [OP_W-1:0] OP_XOR   = 5'd9;
    localparam logic [OP_W-1:0] OP_BEQ   = 5'd10;
    localparam logic [OP_W-1:0] OP_BGE   = 5'd11;
    localparam logic [OP_W-1:0] OP_BNE   = 5'd12;
    localparam logic [OP_W-1:0] OP_BGEU  = 5'd13;
    localparam logic [OP_W-1:0] OP_LUI   = 5'd14;
    localparam logic [OP_W-1:0] OP_AUIPC = 5'd15;
    localparam logic [OP_W-1:0] OP_JAL   = 5'd16;
    localparam logic [OP_W-1:0] OP_JALR  = 5'd17;
    localparam logic [OP_W-1:0] OP_LB    = 5'd18;
    localparam logic [OP_W-1:0] OP_LH    = 5'd19;
    localparam logic [OP_W-1:0] OP_LW    = 5'd20;
    localparam logic [OP_W-1:0] OP_LBU   = 5'd21;
    localparam logic [OP_W-1:0] OP_LHU   = 5'd22;
    localparam logic [OP_W-1:0] OP_SB    = 5'd23;
    localparam logic [OP_W-1:0] OP_SH    = 5'd24;
    localparam logic [OP_W-1:0] OP_SW    = 5'd25;
    localparam logic [OP_W-1:0] OP_BLT   = 5'd26;
    localparam logic [OP_W-1:0] OP_BLTU  = 5'd27;
    // link register fixed to ra.
    localparam logic [OP_W-1:0] OP_JAL_C = 5'd28;
    localparam logic [OP_W-1:0] OP_NONE  = 5'd31;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes and funct7 values.
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [6:0] F7_ZERO = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // compressed quadrants.
    localparam logic [1:0] Q0 = 2'b00;
    localparam logic [1:0] Q1 = 2'b01;
    localparam logic [1:0] Q2 = 2'b10;

    localparam logic [REG_W-1:0] REG_RA    = 5'd1;
    localparam logic [REG_W-1:0] REG_SP    = 5'd2;
    localparam logic [REG_W-1:0] CREG_BASE = 5'd8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one instruction word, two views.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_base_view_t;

    typedef struct packed {
        logic [15:0] upper;
        logic [2:0]  funct3;
        logic        b12;
        logic [4:0]  rd_rs1;
        logic [4:0]  rs2;
        logic [1:0]  quadrant;
    } rv_c_view_t;

    typedef union packed {
        rv_base_view_t b;
        rv_c_view_t    c;
    } rv_instr_u;

endpackage

// ==== hw/rvc_decoder.sv ====
`timescale 1ns/100ps

module rvc_decoder (
    input  rv_decode_pkg::rv_instr_u        instruction,
    output logic [rv_decode_pkg::OP_W-1:0]  op,
    output logic [rv_decode_pkg::REG_W-1:0] rs1,
    output logic [rv_decode_pkg::REG_W-1:0] rs2,
    output logic [rv_decode_pkg::REG_W-1:0] rd,
    output logic [rv_decode_pkg::XLEN-1:0]  imm,
    output logic                            has_imm
);

    // rd'/rs1' in [9:7], rd'/rs2' in [4:2].
    logic [rv_decode_pkg::REG_W-1:0] reg_hi;
    logic [rv_decode_pkg::REG_W-1:0] reg_lo;

    logic [rv_decode_pkg::XLEN-1:0] imm_ci;
    logic [rv_decode_pkg::XLEN-1:0] imm_sp16;
    logic [rv_decode_pkg::XLEN-1:0] imm_lui;
    logic [rv_decode_pkg::XLEN-1:0] imm_cj;
    logic [rv_decode_pkg::XLEN-1:0] imm_word;
    logic [rv_decode_pkg::XLEN-1:0] imm_sh;

    assign reg_hi = {2'b00, instruction[9:7]} + rv_decode_pkg::CREG_BASE;
    assign reg_lo = {2'b00, instruction[4:2]} + rv_decode_pkg::CREG_BASE;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scattered immediates.
    assign imm_ci   = {{26{instruction.c.b12}}, instruction.c.b12, instruction.c.rs2};
    assign imm_sp16 = {{22{instruction[12]}}, instruction[12], instruction[4:3],
                       instruction[5], instruction[2], instruction[6], 4'b0};
    assign imm_lui  = {{14{instruction[12]}}, instruction[12], instruction[6:2], 12'b0};
    assign imm_cj   = {{20{instruction[12]}}, instruction[12], instruction[8],
                       instruction[10:9], instruction[6], instruction[7], instruction[2],
                       instruction[11], instruction[5:3], 1'b0};
    assign imm_word = {25'b0, instruction[5], instruction[12:10], instruction[6], 2'b0};
    assign imm_sh   = {26'b0, instruction.c.b12, instruction.c.rs2};

    always_comb begin
        op      = rv_decode_pkg::OP_NONE;
        rs1     = '0;
        rs2     = '0;
        rd      = '0;
        imm     = '0;
        has_imm = 1'b0;
        case (instruction.c.quadrant)
            rv_decode_pkg::Q0: begin
                // c.lw and c.sw only.
                if (instruction.c.funct3 == 3'b010) begin
                    op = rv_decode_pkg::OP_LW;
                    rd = reg_lo;
                end else if (instruction.c.funct3 == 3'b110) begin
                    op  = rv_decode_pkg::OP_SW;
                    rs2 = reg_lo;
                end
                rs1     = reg_hi;
                imm     = imm_word;
                has_imm = 1'b1;
            end
            rv_decode_pkg::Q1: begin
                has_imm = 1'b1;
                case (instruction.c.funct3)
                    3'b000: begin
                        op  = rv_decode_pkg::OP_ADD;
                        rs1 = instruction.c.rd_rs1;
                        rd  = instruction.c.rd_rs1;
                        imm = imm_ci;
                    end
                    3'b001: begin
                        op  = rv_decode_pkg::OP_JAL_C;
                        rd  = rv_decode_pkg::REG_RA;
                        imm = imm_cj;
                    end
                    3'b011: begin
                        if (instruction.c.rd_rs1 == rv_decode_pkg::REG_SP) begin
                            op  = rv_decode_pkg::OP_ADD;
                            rs1 = rv_decode_pkg::REG_SP;
                            rd  = rv_decode_pkg::REG_SP;
                            imm = imm_sp16;
                        end else begin
                            op  = rv_decode_pkg::OP_LUI;
                            rd  = instruction.c.rd_rs1;
                            imm = imm_lui;
                        end
                    end
                    3'b100: begin
                        rs1 = reg_hi;
                        rd  = reg_hi;
                        case (instruction[11:10])
                            2'b00: begin
                                op  = instruction.c.b12 ? rv_decode_pkg::OP_NONE :
                                      rv_decode_pkg::OP_SRL;
                                imm = imm_sh;
                            end
                            2'b01: begin
                                op  = instruction.c.b12 ? rv_decode_pkg::OP_NONE :
                                      rv_decode_pkg::OP_SRA;
                                imm = imm_sh;
                            end
                            2'b10: begin
                                op  = rv_decode_pkg::OP_AND;
                                imm = imm_ci;
                            end
                            default: begin
                                // register-register group.
                                has_imm = 1'b0;
                                rs2     = reg_lo;
                                if (!instruction.c.b12) begin
                                    case (instruction[6:5])
                                        2'b00: op = rv_decode_pkg::OP_SUB;
                                        2'b01: op = rv_decode_pkg::OP_XOR;
                                        2'b10: op = rv_decode_pkg::OP_OR;
                                        default: op = rv_decode_pkg::OP_AND;
                                    endcase
                                end
                            end
                        endcase
                    end
                    default: op = rv_decode_pkg::OP_NONE;
                endcase
            end
            rv_decode_pkg::Q2: begin
                if (instruction.c.funct3 == 3'b000 && !instruction.c.b12) begin
                    op      = rv_decode_pkg::OP_SLL;
                    rs1     = instruction.c.rd_rs1;
                    rd      = instruction.c.rd_rs1;
                    imm     = imm_sh;
                    has_imm = 1'b1;
                end else if (instruction.c.funct3 == 3'b100 && instruction.c.b12) begin
                    // c.jr and c.mv have b12 clear and stay unsupported.
                    if (instruction.c.rs2 != 5'd0) begin
                        op  = rv_decode_pkg::OP_ADD;
                        rs1 = instruction.c.rd_rs1;
                        rs2 = instruction.c.rs2;
                        rd  = instruction.c.rd_rs1;
                    end else if (instruction.c.rd_rs1 != 5'd0) begin
                        op  = rv_decode_pkg::OP_JALR;
                        rs1 = instruction.c.rd_rs1;
                        rd  = rv_decode_pkg::REG_RA;
                    end
                end
            end
            default: op = rv_decode_pkg::OP_NONE;
        endcase
        if (op == rv_decode_pkg::OP_NONE) begin
            rs1     = '0;
            rs2     = '0;
            rd      = '0;
            imm     = '0;
            has_imm = 1'b0;
        end
    end

endmodule

// ==== verification/decode_stage_tb.sv ====
`timescale 1ns/100ps

module decode_stage_tb;

    localparam int NUM_VECTORS  = 38;
    localparam int FIELDS       = 7;
    localparam int RESET_CYCLES = 2;
    localparam int CYCLE_LIMIT  = NUM_VECTORS + 10;

    logic                            clk;
    logic                            rst;
    logic [rv_decode_pkg::XLEN-1:0]  instruction;
    logic [rv_decode_pkg::OP_W-1:0]  op;
    logic [rv_decode_pkg::REG_W-1:0] rs1;
    logic [rv_decode_pkg::REG_W-1:0] rs2;
    logic [rv_decode_pkg::REG_W-1:0] rd;
    logic [rv_decode_pkg::XLEN-1:0]  imm;
    logic                            has_imm;

    // instr, op, rs1, rs2, rd, imm, has_imm per case.
    logic [31:0] vectors [0:NUM_VECTORS*FIELDS-1];
    int          cycles = 0;

    decode_stage uut (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .has_imm     (has_imm)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Test failed");
            $fatal(1, "timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking.
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "output mismatch on %s", name);
        end
    endtask

    task automatic check_reset_state();
        check_value("op", 32'(rv_decode_pkg::OP_NONE), 32'(op));
        check_value("rs1", 32'd0, 32'(rs1));
        check_value("rs2", 32'd0, 32'(rs2));
        check_value("rd", 32'd0, 32'(rd));
        check_value("imm", 32'd0, imm);
        check_value("has_imm", 32'd0, 32'(has_imm));
    endtask

    task automatic check_outputs(input int idx);
        int base;
        base = idx * FIELDS;
        check_value("op", vectors[base + 1], 32'(op));
        check_value("rs1", vectors[base + 2], 32'(rs1));
        check_value("rs2", vectors[base + 3], 32'(rs2));
        check_value("rd", vectors[base + 4], 32'(rd));
        check_value("imm", vectors[base + 5], imm);
        check_value("has_imm", vectors[base + 6], 32'(has_imm));
    endtask

    // a short file leaves the fill pattern, which no valid case matches.
    task automatic load_vectors();
        for (int i = 0; i < NUM_VECTORS * FIELDS; i++) begin
            vectors[i] = 32'hbad00000 ^ i;
        end
        $readmemh("verification/decode_vectors.txt", vectors);
        for (int i = 0; i < NUM_VECTORS; i++) begin
            if (vectors[i*FIELDS + 1] > 32'd31 || vectors[i*FIELDS + 6] > 32'd1) begin
                $display("Test failed");
                $fatal(1, "vector file is missing or malformed at case %0d", i);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus.
    initial begin
        rst         = 1'b0;
        instruction = 32'h002081b3;
        load_vectors();

        // a live word on the input must not leak through reset.
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_reset_state();
        end

        rst         = 1'b1;
        instruction = vectors[0];
        for (int i = 0; i < NUM_VECTORS; i++) begin
            @(negedge clk);
            check_outputs(i);
            if (i + 1 < NUM_VECTORS) begin
                instruction = vectors[(i + 1) * FIELDS];
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule

// ==== verification/decode_vectors.txt ====
// instr op rs1 rs2 rd imm has_imm, all hex, one case per line.
// expected outputs appear one cycle after the instruction is applied.
002081b3 00 01 02 03 00000000 0  // add x3, x1, x2
407302b3 08 06 07 05 00000000 0  // sub x5, x6, x7
00c5d533 04 0b 0c 0a 00000000 0  // srl x10, x11, x12
40c5d533 07 0b 0c 0a 00000000 0  // sra x10, x11, x12
ffb10093 00 02 00 01 fffffffb 1  // addi x1, x2, -5
00729213 03 05 00 04 00000007 1  // slli x4, x5, 7
01f3d313 04 07 00 06 0000001f 1  // srli x6, x7, 31
4034d413 07 09 00 08 00000003 1  // srai x8, x9, 3
abcde3b7 0e 00 00 07 abcde000 1  // lui x7, 0xabcde
80001497 0f 00 00 09 80001000 1  // auipc x9, 0x80001
001000ef 10 00 00 01 00000800 1  // jal x1, +2048
ffdff06f 10 00 00 00 fffffffc 1  // jal x0, -4
00208863 0a 01 02 00 00000010 1  // beq x1, x2, +16
fe419ce3 0c 03 04 00 fffffff8 1  // bne x3, x4, -8
0020a063 1f 00 00 00 00000000 0  // branch funct3 2
00c32283 14 06 00 05 0000000c 1  // lw x5, 12(x6)
004280e7 11 05 00 01 00000004 1  // jalr x1, 4(x5)
fe712623 19 02 07 00 ffffffec 1  // sw x7, -20(x2)
00033283 1f 00 00 00 00000000 0  // load funct3 3
00713023 1f 00 00 00 00000000 0  // store funct3 3
0ff0000f 1f 00 00 00 00000000 0  // fence
00004504 14 0a 00 09 00000008 1  // c.lw x9, 8(x10)
0000dc7c 19 08 0f 00 0000007c 1  // c.sw x15, 124(x8)
000012f5 00 05 00 05 fffffffd 1  // c.addi x5, -3
0000200d 1c 00 00 01 00000022 1  // c.jal +34
00007305 0e 00 00 06 fffe1000 1  // c.lui x6, 0xfffe1
00007139 00 02 00 02 ffffffc0 1  // c.addi16sp -64
00008091 04 09 00 09 00000004 1  // c.srli x9, 4
00008505 07 0a 00 0a 00000001 1  // c.srai x10, 1
000099fd 01 0b 00 0b ffffffff 1  // c.andi x11, -1
00008c05 08 08 09 08 00000000 0  // c.sub x8, x9
00008fe1 01 0f 08 0f 00000000 0  // c.and x15, x8
00000196 03 03 00 03 00000005 1  // c.slli x3, 5
00009302 11 06 00 01 00000000 0  // c.jalr x6
00009216 00 04 05 04 00000000 0  // c.add x4, x5
00000000 1f 00 00 00 00000000 0  // all-zero word
00008082 1f 00 00 00 00000000 0  // c.jr x1
0000829a 1f 00 00 00 00000000 0  // c.mv x5, x6

// ==== vlog.f ====
hw/rv_decode_pkg.sv
hw/rv32_base_decoder.sv
hw/rvc_decoder.sv
hw/decode_stage.sv
verification/decode_stage_tb.sv
